// ==== common/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// first fetch address after reset
`define RESET_PC 32'h8000_0000

// instruction memory size in 32-bit words
`define IMEM_DEPTH 256

// word index width; pc bits [IMEM_AW+1:2] select the word
`define IMEM_AW $clog2(`IMEM_DEPTH)

// index wraps, so any pc maps into the array

`endif

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    // rv32i major opcodes, bits [6:0]
    localparam logic [6:0] opc_alu    = 7'b0110011;
    localparam logic [6:0] opc_alui   = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    // the six rv32 layouts, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;     // sign bit
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;     // sign bit
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, every format view over the same bits
    typedef union packed {
        logic [31:0] word;
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        u_fmt_t      u;
        j_fmt_t      j;
    } inst_u;

    // nine classes need four bits
    typedef enum logic [3:0] {
        op_alu, op_alui, op_load, op_store, op_branch,
        op_jal, op_jalr, op_upper, op_other
    } op_class_e;

    // fetch fsm states
    typedef enum logic [1:0] {
        fs_idle, fs_data, fs_wait_ready
    } fetch_state_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        op_class_e   cls;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [31:0] imm;       // sign extended
        logic        redirect;  // static taken
    } dec_rec_t;

endpackage

// ==== ifu/ifu.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

// fetch unit with the pc register and the idle / data / wait_ready machine
// one instruction in flight at a time
module ifu import fetch_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                fready,     // decode can take finst
    input  logic                jump_en,    // combinational redirect from decode
    input  logic [31:0]         jump_pc,
    output logic                rd_en,
    output logic [`IMEM_AW-1:0] rd_addr,
    input  logic [31:0]         rd_data,    // valid one cycle after rd_en
    output logic                fvalid,
    output logic [31:0]         fpc,
    output logic [31:0]         finst
);

    fetch_state_e state;
    fetch_state_e state_nxt;
    logic [31:0]  pc;
    logic [31:0]  pc_nxt;
    logic         xfer;

    assign xfer = fvalid & fready;  // handshake completes this cycle

    // jump_en only matters on the transfer cycle
    assign pc_nxt = jump_en ? jump_pc : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fs_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            fs_idle: begin
                state_nxt = fs_data;        // read issued this cycle
            end
            fs_data: begin
                state_nxt = fs_wait_ready;  // rd_data captured at the edge
            end
            fs_wait_ready: begin
                if (fready) begin
                    state_nxt = fs_idle;
                end
            end
            default: begin
                state_nxt = fs_idle;
            end
        endcase
    end

    // read is issued only from idle and never in reset
    assign rd_en   = (state == fs_idle) & ~rst;
    assign rd_addr = pc[`IMEM_AW+1:2];      // word index wraps

    // pc moves only on transfer so fpc holds while fvalid
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (xfer) begin
            pc <= pc_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fvalid <= 1'b0;
        end else if (state == fs_data) begin
            fvalid <= 1'b1;
        end else if (xfer) begin
            fvalid <= 1'b0;     // dropped as we return to idle
        end
    end

    // payload register
    always_ff @(posedge clk) begin
        if (state == fs_data) begin
            finst <= rd_data;
        end
    end

    assign fpc = pc;

endmodule

// ==== src/inst_sram.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

// word wide instruction memory
// registered read port, separate load port for program init
module inst_sram (
    input  logic                clk,
    input  logic                rd_en,
    input  logic [`IMEM_AW-1:0] rd_addr,
    output logic [31:0]         rd_data,
    input  logic                load_en,
    input  logic [`IMEM_AW-1:0] load_addr,
    input  logic [31:0]         load_data
);

    logic [31:0] mem [`IMEM_DEPTH];    // contents undefined until loaded

    // load port, only driven while the core is held in reset
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // read data holds when rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];   // one cycle latency
        end
    end

endmodule

// ==== src/idu.sv ====
`timescale 1ns/1ps

// decode stage
// splits finst into fields, builds the immediate, static redirect back to fetch
module idu import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,      // level, holds decode and so fetch
    input  logic        fvalid,
    input  logic [31:0] fpc,
    input  logic [31:0] finst,
    output logic        fready,
    output logic        jump_en,
    output logic [31:0] jump_pc,
    output logic        dec_valid,  // one cycle strobe
    output dec_rec_t    dec_rec
);

    inst_u       iv;
    op_class_e   cls;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] imm;
    logic        xfer;
    dec_rec_t    rec_d;

    assign iv.word = finst;

    assign fready = ~stall;
    assign xfer   = fvalid & fready;

    // opcode classification
    always_comb begin
        case (iv.r.opcode)
            opc_alu:    cls = op_alu;
            opc_alui:   cls = op_alui;
            opc_load:   cls = op_load;
            opc_store:  cls = op_store;
            opc_branch: cls = op_branch;
            opc_jal:    cls = op_jal;
            opc_jalr:   cls = op_jalr;
            opc_lui,
            opc_auipc:  cls = op_upper;     // lui and auipc share u format
            default:    cls = op_other;
        endcase
    end

    // immediates for each format, all sign extended from bit 31
    assign imm_i = {{20{iv.i.imm_11_0[11]}}, iv.i.imm_11_0};
    assign imm_s = {{20{iv.s.imm_11_5[6]}}, iv.s.imm_11_5, iv.s.imm_4_0};
    assign imm_b = {{19{iv.b.imm_12}}, iv.b.imm_12, iv.b.imm_11,
                    iv.b.imm_10_5, iv.b.imm_4_1, 1'b0};
    assign imm_u = {iv.u.imm_31_12, 12'b0};
    assign imm_j = {{11{iv.j.imm_20}}, iv.j.imm_20, iv.j.imm_19_12,
                    iv.j.imm_11, iv.j.imm_10_1, 1'b0};

    // pick by class
    always_comb begin
        case (cls)
            op_alui,
            op_load,
            op_jalr:   imm = imm_i;
            op_store:  imm = imm_s;
            op_branch: imm = imm_b;
            op_jal:    imm = imm_j;
            op_upper:  imm = imm_u;
            default:   imm = 32'd0;     // r format and unknown carry none
        endcase
    end

    // static prediction
    // jal always, branch only when the offset is negative
    assign jump_en = (cls == op_jal) | ((cls == op_branch) & imm_b[31]);
    assign jump_pc = fpc + imm;     // imm is imm_b or imm_j whenever jump_en

    // record fields come from the raw bit positions whatever the format
    always_comb begin
        rec_d.pc       = fpc;
        rec_d.inst     = finst;
        rec_d.cls      = cls;
        rec_d.rd       = iv.r.rd;
        rec_d.rs1      = iv.r.rs1;
        rec_d.rs2      = iv.r.rs2;
        rec_d.funct3   = iv.r.funct3;
        rec_d.imm      = imm;
        rec_d.redirect = jump_en;
    end

    // strobe one cycle after the transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= xfer;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            dec_rec <= rec_d;   // held until the next transfer
        end
    end

endmodule

// ==== src/fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

// fetch front end: ifu, instruction memory and decode
module fetch_top import fetch_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                load_en,    // program load, only during reset
    input  logic [`IMEM_AW-1:0] load_addr,
    input  logic [31:0]         load_data,
    output logic                dec_valid,
    output dec_rec_t            dec_rec
);

    // ifu <-> sram
    logic                rd_en;
    logic [`IMEM_AW-1:0] rd_addr;
    logic [31:0]         rd_data;

    // ifu <-> idu
    logic                fvalid;
    logic                fready;
    logic [31:0]         fpc;
    logic [31:0]         finst;
    logic                jump_en;
    logic [31:0]         jump_pc;

    ifu ifu0 (
        .clk     (clk),
        .rst     (rst),
        .fready  (fready),
        .jump_en (jump_en),
        .jump_pc (jump_pc),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .fvalid  (fvalid),
        .fpc     (fpc),
        .finst   (finst)
    );

    inst_sram sram0 (
        .clk       (clk),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    idu idu0 (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .fvalid    (fvalid),
        .fpc       (fpc),
        .finst     (finst),
        .fready    (fready),
        .jump_en   (jump_en),
        .jump_pc   (jump_pc),
        .dec_valid (dec_valid),
        .dec_rec   (dec_rec)
    );

endmodule

// ==== test/fetch_checker.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

// reference model for the fetch front end
// mirrors the loaded program, walks the expected pc and decodes each word itself
module fetch_checker import fetch_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_en,
    input  logic [`IMEM_AW-1:0] load_addr,
    input  logic [31:0]         load_data,
    input  logic                dec_valid,
    input  dec_rec_t            dec_rec,
    input  logic                log_pcs,    // keep pc stream as reference
    input  logic                match_pcs,  // compare pc stream with the kept one
    output int                  rec_count,
    output int                  err_count
);

    logic [31:0] mirror [`IMEM_DEPTH];     // copy of the load port traffic
    logic [31:0] pc_log [$];                // pcs of the unstalled run
    logic [31:0] exp_pc;
    logic        rst_q = 1'b0;
    int          log_idx;

    initial begin
        rec_count = 0;
        err_count = 0;
    end

    // class straight from the isa opcode table
    function automatic op_class_e class_of(input logic [31:0] w);
        case (w[6:0])
            opc_alu:    return op_alu;
            opc_alui:   return op_alui;
            opc_load:   return op_load;
            opc_store:  return op_store;
            opc_branch: return op_branch;
            opc_jal:    return op_jal;
            opc_jalr:   return op_jalr;
            opc_lui:    return op_upper;
            opc_auipc:  return op_upper;
            default:    return op_other;
        endcase
    endfunction

    // immediates rebuilt from raw bit positions
    function automatic logic [31:0] imm_b_of(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] imm_j_of(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic [31:0] imm_of(input logic [31:0] w);
        case (class_of(w))
            op_alui, op_load, op_jalr: return {{20{w[31]}}, w[31:20]};
            op_store:  return {{20{w[31]}}, w[31:25], w[11:7]};
            op_branch: return imm_b_of(w);
            op_jal:    return imm_j_of(w);
            op_upper:  return {w[31:12], 12'b0};
            default:   return 32'd0;   // r format, unknown
        endcase
    endfunction

    // static rule: jal always, branch only backward
    function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] w);
        if (w[6:0] == opc_jal) begin
            return pc + imm_j_of(w);
        end else if (w[6:0] == opc_branch && w[31]) begin
            return pc + imm_b_of(w);
        end
        return pc + 32'd4;
    endfunction

    task automatic report(input string msg);
        $display("error: %s (expected pc %h)", msg, exp_pc);
        err_count++;
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h (pc %h)", name, got, exp, exp_pc);
            err_count++;
        end
    endtask

    task automatic check_record();
        logic [31:0] w;
        op_class_e   cls;
        logic        redir;
        w     = mirror[exp_pc[`IMEM_AW+1:2]];  // index wraps like the sram
        cls   = class_of(w);
        redir = (cls == op_jal) || (cls == op_branch && w[31]);
        check_field("pc", dec_rec.pc, exp_pc);
        check_field("inst", dec_rec.inst, w);
        check_field("cls", 32'(dec_rec.cls), 32'(cls));
        check_field("rd", 32'(dec_rec.rd), 32'(w[11:7]));
        check_field("rs1", 32'(dec_rec.rs1), 32'(w[19:15]));
        check_field("rs2", 32'(dec_rec.rs2), 32'(w[24:20]));
        check_field("funct3", 32'(dec_rec.funct3), 32'(w[14:12]));
        check_field("imm", dec_rec.imm, imm_of(w));
        check_field("redirect", 32'(dec_rec.redirect), 32'(redir));
        if (log_pcs) begin
            pc_log.push_back(dec_rec.pc);
        end
        if (match_pcs) begin
            if (log_idx >= pc_log.size()) begin
                report("more records than in the unstalled run");
            end else begin
                check_field("pc_unstalled", dec_rec.pc, pc_log[log_idx]);
            end
            log_idx++;
        end
        rec_count++;
        exp_pc = next_pc(exp_pc, w);   // model pc, never resynced to the dut
    endtask

    always @(posedge clk) begin
        rst_q <= rst;
        if (load_en) begin
            mirror[load_addr] = load_data;
        end
        if (rst) begin
            exp_pc  = `RESET_PC;
            log_idx = 0;
            if (log_pcs) begin
                pc_log.delete();        // fresh reference run
            end
            if (rst_q && dec_valid !== 1'b0) begin
                report("dec_valid high during reset");
            end
        end else if (dec_valid === 1'b1) begin
            check_record();
        end else if (dec_valid !== 1'b0) begin
            report("dec_valid unknown after reset");
        end
    end

endmodule

// ==== test/tb_fetch.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

// testbench for fetch_top with random programs and optional random stall
module tb_fetch import fetch_pkg::*; ();

    logic                clk;
    logic                rst;
    logic                stall;
    logic                load_en;
    logic [`IMEM_AW-1:0] load_addr;
    logic [31:0]         load_data;
    logic                dec_valid;
    dec_rec_t            dec_rec;
    logic                log_pcs;
    logic                match_pcs;
    int                  rec_count;
    int                  err_count;
    int                  seed;
    int                  tests_failed;
    bit                  timed_out;

    always #10 clk = ~clk;     // 20 ns period

    fetch_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .dec_valid (dec_valid),
        .dec_rec   (dec_rec)
    );

    fetch_checker chk0 (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .dec_valid (dec_valid),
        .dec_rec   (dec_rec),
        .log_pcs   (log_pcs),
        .match_pcs (match_pcs),
        .rec_count (rec_count),
        .err_count (err_count)
    );

    // opcodes that never redirect
    function automatic logic [6:0] plain_opcode(input logic [2:0] p);
        case (p)
            3'd0:    return opc_alu;
            3'd1:    return opc_alui;
            3'd2:    return opc_load;
            3'd3:    return opc_store;
            3'd4:    return opc_lui;
            3'd5:    return opc_auipc;
            3'd6:    return opc_jalr;    // jalr is not predicted
            default: return opc_alui;
        endcase
    endfunction

    // mode 0 plain, 1 with jal, 2 with branches, 3 anything
    function automatic logic [31:0] make_word(input int mode);
        logic [31:0] w;
        logic [31:0] pick;
        w    = $random(seed);
        pick = $random(seed);
        case (mode)
            0: w[6:0] = plain_opcode(pick[2:0]);
            1: w[6:0] = pick[3] ? opc_jal : plain_opcode(pick[2:0]);
            2: w[6:0] = pick[3] ? opc_branch : plain_opcode(pick[2:0]);
            default: begin
                if (pick[3:0] == 4'd14) begin
                    w[6:0] = opc_branch;
                end else if (pick[3:0] == 4'd15) begin
                    w[6:0] = opc_jal;
                end else if (pick[3]) begin
                    w[6:0] = plain_opcode(pick[2:0]);
                end             // otherwise raw random opcode and mostly op_other
            end
        endcase
        return w;
    endfunction

    // reset with optional reload then 10 more reset cycles
    task automatic start_test(input int mode, input bit reload, input bit lg, input bit mt);
        @(posedge clk);
        rst       <= 1'b1;
        stall     <= 1'b0;
        log_pcs   <= lg;
        match_pcs <= mt;
        if (reload) begin
            for (int i = 0; i < `IMEM_DEPTH; i++) begin
                load_en   <= 1'b1;
                load_addr <= i[`IMEM_AW-1:0];
                load_data <= make_word(mode);
                @(posedge clk);
            end
        end
        load_en <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    endtask

    // bounded wait for n more records sampled on the falling edge
    task automatic wait_records(input int target, input int limit, input bit rand_stall,
                                output bit ok);
        int          cycles;
        logic [31:0] r;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < limit) begin
            @(posedge clk);
            if (rand_stall) begin
                r = $random(seed);
                stall <= r[0];          // about half the cycles stalled
            end
            @(negedge clk);
            ok = (rec_count >= target);
            cycles++;
        end
    endtask

    task automatic run_test(input string name, input int mode, input bit reload, input int n,
                            input bit rand_stall, input bit lg, input bit mt);
        int    rec0;
        int    err0;
        bit    ok;
        string verdict;
        if (timed_out) begin
            return;
        end
        err0 = err_count;
        start_test(mode, reload, lg, mt);
        @(negedge clk);
        rec0 = rec_count;
        wait_records(rec0 + n, n * 40 + 100, rand_stall, ok);
        if (!ok) begin
            $display("test %s: no decoded output within timeout", name);
            timed_out = 1'b1;
        end
        if (ok && err_count == err0) begin
            verdict = "ok";
        end else begin
            verdict = "failed";
            tests_failed++;
        end
        $display("test %-10s %0d records, %0d errors, %s", name, rec_count - rec0,
                 err_count - err0, verdict);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        stall        = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = 32'd0;
        log_pcs      = 1'b0;
        match_pcs    = 1'b0;
        seed         = 32'h20e8_a04e;
        tests_failed = 0;
        timed_out    = 1'b0;
        run_test("reset", 0, 1'b1, 20, 1'b0, 1'b0, 1'b0);
        run_test("sequential", 0, 1'b1, 200, 1'b0, 1'b0, 1'b0);
        run_test("jal", 1, 1'b1, 200, 1'b0, 1'b0, 1'b0);
        run_test("branch", 2, 1'b1, 200, 1'b0, 1'b0, 1'b0);
        run_test("decode", 3, 1'b1, 300, 1'b0, 1'b1, 1'b0);  // also the reference pc run
        run_test("stall", 3, 1'b0, 300, 1'b1, 1'b0, 1'b1);   // same program under stall
        $display("total: %0d records, %0d errors, %0d tests failed",
                 rec_count, err_count, tests_failed);
        if (timed_out || err_count != 0 || tests_failed != 0) begin
            $display("** FAIL **");
        end else begin
            $display("** PASS **");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/fetch_pkg.sv
ifu/ifu.sv
src/inst_sram.sv
src/idu.sv
src/fetch_top.sv
test/fetch_checker.sv
test/tb_fetch.sv

// ==== Makefile ====
# Verilator build and run for the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= verilog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# build, run, then decide on the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
